// ==== design/dcache_config.svh ====
`ifndef DCACHE_CONFIG_SVH
`define DCACHE_CONFIG_SVH

// data word, also the address width
`define DC_WORD_W     32

// geometry
`define DC_SETS       8
`define DC_IDX_W      3
`define DC_TAG_W      26
`define DC_WAYS       2
`define DC_BLK_WORDS  2

// last set visited by the halt walk
`define DC_FLUSH_LAST (`DC_SETS - 1)

`endif

// ==== design/cache_types_pkg.sv ====
`include "dcache_config.svh"

package cache_types_pkg;

        typedef logic [`DC_WORD_W-1:0] word_t;

        // tag | index | block offset | byte offset
        typedef struct packed {
                logic [`DC_TAG_W-1:0] tag;
                logic [`DC_IDX_W-1:0] idx;
                logic                 blkoff;
                logic [1:0]           bytoff;
        } dc_addr_t;

        // one line of one way
        typedef struct packed {
                logic                         valid;
                logic                         dirty;
                logic [`DC_TAG_W-1:0]         tag;
                word_t [`DC_BLK_WORDS-1:0]    data;
        } dc_frame_t;

        typedef logic [$clog2(`DC_WAYS)-1:0] way_sel_t;

endpackage

// ==== design/cache_ctrl_pkg.sv ====
package cache_ctrl_pkg;

        typedef enum logic [3:0] {
                IDLE,
                WB1,
                WB2,
                AL1,
                AL2,
                FLUSH_SCAN,
                FLUSH_WB1,
                FLUSH_WB2,
                DONE
        } dc_state_t;

        // memory port request, decoded into dREN and dWEN
        typedef enum logic [1:0] {
                NONE,
                READ,
                WRITE
        } mem_cmd_t;

endpackage

// ==== design/dcache_ways.sv ====
`timescale 1ns/1ps
`include "dcache_config.svh"

module dcache_ways import cache_types_pkg::*; (
        input  logic                 CLK,
        input  logic                 nRST,
        input  dc_addr_t             req_addr,
        input  logic                 scan_mode,
        input  logic [`DC_IDX_W-1:0] scan_idx,
        input  logic                 fill_en,
        input  way_sel_t             fill_way,
        input  logic                 fill_word,
        input  word_t                fill_data,
        input  logic                 line_valid_set,
        input  logic                 line_dirty_set,
        input  logic                 line_clean,
        input  logic                 lru_touch,
        output logic                 hit,
        output way_sel_t             hit_way,
        output way_sel_t             victim_way,
        output logic                 victim_dirty,
        output logic [`DC_TAG_W-1:0] victim_tag,
        output word_t                rd_data,
        output logic                 scan_dirty,
        output way_sel_t             scan_way
);

        dc_frame_t            frames [`DC_WAYS][`DC_SETS];
        // way to evict next in each set
        logic [`DC_SETS-1:0]  lru;

        logic [`DC_IDX_W-1:0] set_idx;
        logic [`DC_WAYS-1:0]  way_match;
        logic [`DC_WAYS-1:0]  way_dirty;
        way_sel_t             rd_way;
        way_sel_t             tag_way;

        assign set_idx = scan_mode ? scan_idx : req_addr.idx;

        always_comb begin
                for (int w = 0; w < `DC_WAYS; w++) begin
                        way_match[w] = frames[w][set_idx].valid &&
                                       (frames[w][set_idx].tag == req_addr.tag);
                        way_dirty[w] = frames[w][set_idx].valid &&
                                       frames[w][set_idx].dirty;
                end
        end

        // lookup is meaningless while walking sets
        assign hit     = !scan_mode && (|way_match);
        assign hit_way = way_match[0] ? 1'b0 : 1'b1;

        assign victim_way   = lru[set_idx];
        assign victim_dirty = way_dirty[victim_way];

        // way 0 gets written back first
        assign scan_dirty = |way_dirty;
        assign scan_way   = way_dirty[0] ? 1'b0 : 1'b1;

        always_comb begin
                if (scan_mode) begin
                        rd_way = scan_way;
                end else if (hit) begin
                        rd_way = hit_way;
                end else begin
                        rd_way = victim_way;
                end
        end

        assign tag_way = scan_mode ? scan_way : victim_way;

        // word select follows the controller
        assign rd_data    = frames[rd_way][set_idx].data[fill_word];
        assign victim_tag = frames[tag_way][set_idx].tag;

        always_ff @(posedge CLK or negedge nRST) begin
                if (!nRST) begin
                        lru <= '0;
                        for (int w = 0; w < `DC_WAYS; w++) begin
                                for (int s = 0; s < `DC_SETS; s++) begin
                                        frames[w][s].valid <= 1'b0;
                                        frames[w][s].dirty <= 1'b0;
                                end
                        end
                end else begin
                        if (fill_en) begin
                                frames[fill_way][set_idx].data[fill_word] <= fill_data;
                        end

                        // line takes the request tag once allocated
                        if (line_valid_set) begin
                                frames[fill_way][set_idx].valid <= 1'b1;
                                frames[fill_way][set_idx].tag   <= req_addr.tag;
                                frames[fill_way][set_idx].dirty <= line_dirty_set;
                        end else if (line_dirty_set) begin
                                frames[fill_way][set_idx].dirty <= 1'b1;
                        end else if (line_clean) begin
                                frames[fill_way][set_idx].dirty <= 1'b0;
                        end

                        // other way becomes the victim
                        if (lru_touch) begin
                                lru[set_idx] <= ~fill_way;
                        end
                end
        end

endmodule

// ==== design/dcache_ctrl.sv ====
`timescale 1ns/1ps
`include "dcache_config.svh"

module dcache_ctrl import cache_types_pkg::*, cache_ctrl_pkg::*; (
        input  logic                 CLK,
        input  logic                 nRST,
        input  logic                 dmemREN,
        input  logic                 dmemWEN,
        input  logic                 halt,
        input  word_t                dmemaddr,
        input  word_t                dmemstore,
        input  logic                 hit,
        input  way_sel_t             hit_way,
        input  way_sel_t             victim_way,
        input  logic                 victim_dirty,
        input  logic [`DC_TAG_W-1:0] victim_tag,
        input  word_t                rd_data,
        input  logic                 scan_dirty,
        input  way_sel_t             scan_way,
        input  logic                 dwait,
        input  word_t                dload,
        output logic                 dhit,
        output logic                 flushed,
        output logic                 dREN,
        output logic                 dWEN,
        output word_t                daddr,
        output word_t                dstore,
        output logic                 fill_en,
        output way_sel_t             fill_way,
        output logic                 fill_word,
        output word_t                fill_data,
        output logic                 line_valid_set,
        output logic                 line_dirty_set,
        output logic                 line_clean,
        output logic                 lru_touch,
        output logic [`DC_IDX_W-1:0] scan_idx,
        output logic                 scan_mode
);

        dc_state_t            state;
        dc_state_t            next_state;
        logic [`DC_IDX_W-1:0] next_scan_idx;
        mem_cmd_t             cmd;
        dc_addr_t             req;
        logic                 req_any;

        assign req     = dmemaddr;
        assign req_any = dmemREN | dmemWEN;

        assign dREN = (cmd == READ);
        assign dWEN = (cmd == WRITE);

        // depends on state only, so the ways can answer within the cycle
        assign scan_mode = (state == FLUSH_SCAN) || (state == FLUSH_WB1) ||
                           (state == FLUSH_WB2);

        always_comb begin
                case (state)
                        IDLE:                   fill_word = req.blkoff;
                        WB2, AL2, FLUSH_WB2:    fill_word = 1'b1;
                        default:                fill_word = 1'b0;
                endcase
        end

        always_ff @(posedge CLK or negedge nRST) begin
                if (!nRST) begin
                        state    <= IDLE;
                        scan_idx <= '0;
                end else begin
                        state    <= next_state;
                        scan_idx <= next_scan_idx;
                end
        end

        always_comb begin
                next_state     = state;
                next_scan_idx  = scan_idx;
                cmd            = NONE;
                dhit           = 1'b0;
                flushed        = 1'b0;
                daddr          = '0;
                dstore         = '0;
                fill_en        = 1'b0;
                fill_way       = victim_way;
                fill_data      = dload;
                line_valid_set = 1'b0;
                line_dirty_set = 1'b0;
                line_clean     = 1'b0;
                lru_touch      = 1'b0;

                case (state)
                        IDLE: begin
                                if (halt) begin
                                        next_state    = FLUSH_SCAN;
                                        next_scan_idx = '0;
                                end else if (req_any && hit) begin
                                        dhit      = 1'b1;
                                        fill_way  = hit_way;
                                        lru_touch = 1'b1;
                                        // store hit goes straight into the line
                                        if (dmemWEN) begin
                                                fill_en        = 1'b1;
                                                fill_data      = dmemstore;
                                                line_dirty_set = 1'b1;
                                        end
                                end else if (req_any) begin
                                        next_state = victim_dirty ? WB1 : AL1;
                                end
                        end

                        // victim write-back, word 0 then word 1
                        WB1, WB2: begin
                                cmd    = WRITE;
                                daddr  = {victim_tag, req.idx, fill_word, 2'b00};
                                dstore = rd_data;
                                if (!dwait) begin
                                        if (state == WB1) begin
                                                next_state = WB2;
                                        end else begin
                                                line_clean = 1'b1;
                                                next_state = AL1;
                                        end
                                end
                        end

                        // allocate into the victim way
                        AL1, AL2: begin
                                cmd     = READ;
                                daddr   = {req.tag, req.idx, fill_word, 2'b00};
                                fill_en = !dwait;
                                // merge store data into the addressed word
                                if (dmemWEN && (req.blkoff == fill_word)) begin
                                        fill_data = dmemstore;
                                end
                                if (!dwait) begin
                                        if (state == AL1) begin
                                                next_state = AL2;
                                        end else begin
                                                line_valid_set = 1'b1;
                                                line_dirty_set = dmemWEN;
                                                lru_touch      = 1'b1;
                                                next_state     = IDLE;
                                        end
                                end
                        end

                        FLUSH_SCAN: begin
                                if (scan_dirty) begin
                                        next_state = FLUSH_WB1;
                                end else if (scan_idx == `DC_IDX_W'(`DC_FLUSH_LAST)) begin
                                        next_state = DONE;
                                end else begin
                                        next_scan_idx = scan_idx + 1'b1;
                                end
                        end

                        // back to scan afterwards, the other way may be dirty too
                        FLUSH_WB1, FLUSH_WB2: begin
                                cmd      = WRITE;
                                fill_way = scan_way;
                                daddr    = {victim_tag, scan_idx, fill_word, 2'b00};
                                dstore   = rd_data;
                                if (!dwait) begin
                                        if (state == FLUSH_WB1) begin
                                                next_state = FLUSH_WB2;
                                        end else begin
                                                line_clean = 1'b1;
                                                next_state = FLUSH_SCAN;
                                        end
                                end
                        end

                        DONE: begin
                                flushed = 1'b1;
                        end

                        default: begin
                                next_state = IDLE;
                        end
                endcase
        end

endmodule

// ==== design/dcache.sv ====
`timescale 1ns/1ps
`include "dcache_config.svh"

module dcache import cache_types_pkg::*; (
        input  logic  CLK,
        input  logic  nRST,
        input  logic  dmemREN,
        input  logic  dmemWEN,
        input  logic  halt,
        input  word_t dmemaddr,
        input  word_t dmemstore,
        input  logic  dwait,
        input  word_t dload,
        output logic  dhit,
        output word_t dmemload,
        output logic  flushed,
        output logic  dREN,
        output logic  dWEN,
        output word_t daddr,
        output word_t dstore
);

        logic                 hit;
        way_sel_t             hit_way;
        way_sel_t             victim_way;
        logic                 victim_dirty;
        logic [`DC_TAG_W-1:0] victim_tag;
        logic                 scan_dirty;
        way_sel_t             scan_way;
        logic                 fill_en;
        way_sel_t             fill_way;
        logic                 fill_word;
        word_t                fill_data;
        logic                 line_valid_set;
        logic                 line_dirty_set;
        logic                 line_clean;
        logic                 lru_touch;
        logic [`DC_IDX_W-1:0] scan_idx;
        logic                 scan_mode;

        dcache_ways ways (
                .CLK            (CLK),
                .nRST           (nRST),
                .req_addr       (dmemaddr),
                .scan_mode      (scan_mode),
                .scan_idx       (scan_idx),
                .fill_en        (fill_en),
                .fill_way       (fill_way),
                .fill_word      (fill_word),
                .fill_data      (fill_data),
                .line_valid_set (line_valid_set),
                .line_dirty_set (line_dirty_set),
                .line_clean     (line_clean),
                .lru_touch      (lru_touch),
                .hit            (hit),
                .hit_way        (hit_way),
                .victim_way     (victim_way),
                .victim_dirty   (victim_dirty),
                .victim_tag     (victim_tag),
                .rd_data        (dmemload),
                .scan_dirty     (scan_dirty),
                .scan_way       (scan_way)
        );

        dcache_ctrl ctrl (
                .CLK            (CLK),
                .nRST           (nRST),
                .dmemREN        (dmemREN),
                .dmemWEN        (dmemWEN),
                .halt           (halt),
                .dmemaddr       (dmemaddr),
                .dmemstore      (dmemstore),
                .hit            (hit),
                .hit_way        (hit_way),
                .victim_way     (victim_way),
                .victim_dirty   (victim_dirty),
                .victim_tag     (victim_tag),
                .rd_data        (dmemload),
                .scan_dirty     (scan_dirty),
                .scan_way       (scan_way),
                .dwait          (dwait),
                .dload          (dload),
                .dhit           (dhit),
                .flushed        (flushed),
                .dREN           (dREN),
                .dWEN           (dWEN),
                .daddr          (daddr),
                .dstore         (dstore),
                .fill_en        (fill_en),
                .fill_way       (fill_way),
                .fill_word      (fill_word),
                .fill_data      (fill_data),
                .line_valid_set (line_valid_set),
                .line_dirty_set (line_dirty_set),
                .line_clean     (line_clean),
                .lru_touch      (lru_touch),
                .scan_idx       (scan_idx),
                .scan_mode      (scan_mode)
        );

endmodule

// ==== verif/clk_gen.sv ====
`timescale 1ns/1ps

module clk_gen (
        output logic CLK,
        output logic nRST
);

        initial begin
                CLK = 1'b0;
                forever #50 CLK = ~CLK;
        end

        // reset held for four rising edges, released on a falling edge
        initial begin
                nRST = 1'b0;
                repeat (4) @(posedge CLK);
                @(negedge CLK);
                nRST = 1'b1;
        end

endmodule

// ==== verif/mem_model.sv ====
`timescale 1ns/1ps

module mem_model import cache_types_pkg::*; (
        input  logic  CLK,
        input  logic  nRST,
        input  logic  dREN,
        input  logic  dWEN,
        input  word_t daddr,
        input  word_t dstore,
        output logic  dwait,
        output word_t dload
);

        word_t      words [256];
        logic [1:0] wait_cnt;
        logic [7:0] widx;
        logic       access;

        assign widx   = daddr[9:2];
        assign access = dREN | dWEN;
        assign dwait  = access && (wait_cnt != 2'd0);
        assign dload  = words[widx];

        initial begin
                for (int i = 0; i < 256; i++) begin
                        // pattern folds in the full byte address
                        words[i] = (32'(i) << 2) * 32'h9E37_79B1 ^ 32'hA5C3_0F1E;
                end
        end

        // wait count for the next transfer is drawn when one completes
        always_ff @(posedge CLK or negedge nRST) begin
                if (!nRST) begin
                        wait_cnt <= 2'd0;
                end else if (access) begin
                        if (wait_cnt != 2'd0) begin
                                wait_cnt <= wait_cnt - 2'd1;
                        end else begin
                                wait_cnt <= 2'($urandom_range(3, 0));
                        end
                end
        end

        always @(posedge CLK) begin
                if (dWEN && !dwait) begin
                        words[widx] <= dstore;
                end
        end

endmodule

// ==== verif/dcache_tb.sv ====
`timescale 1ns/1ps

module dcache_tb import cache_types_pkg::*; ();

        localparam int RESET_TIMEOUT = 20;
        localparam int HIT_TIMEOUT   = 200;
        localparam int FLUSH_TIMEOUT = 1000;

        logic  CLK;
        logic  nRST;
        logic  dmemREN;
        logic  dmemWEN;
        logic  halt;
        word_t dmemaddr;
        word_t dmemstore;
        logic  dwait;
        word_t dload;
        logic  dhit;
        word_t dmemload;
        logic  flushed;
        logic  dREN;
        logic  dWEN;
        word_t daddr;
        word_t dstore;

        // expected memory image updated on every completed store
        word_t ref_mem [256];
        int    mem_reads;

        clk_gen clocks (
                .CLK  (CLK),
                .nRST (nRST)
        );

        mem_model memory (
                .CLK    (CLK),
                .nRST   (nRST),
                .dREN   (dREN),
                .dWEN   (dWEN),
                .daddr  (daddr),
                .dstore (dstore),
                .dwait  (dwait),
                .dload  (dload)
        );

        dcache uut (
                .CLK       (CLK),
                .nRST      (nRST),
                .dmemREN   (dmemREN),
                .dmemWEN   (dmemWEN),
                .halt      (halt),
                .dmemaddr  (dmemaddr),
                .dmemstore (dmemstore),
                .dwait     (dwait),
                .dload     (dload),
                .dhit      (dhit),
                .dmemload  (dmemload),
                .flushed   (flushed),
                .dREN      (dREN),
                .dWEN      (dWEN),
                .daddr     (daddr),
                .dstore    (dstore)
        );

        function automatic word_t ref_word(input word_t addr);
                return ref_mem[addr[9:2]];
        endfunction

        function automatic word_t mem_word(input word_t addr);
                return memory.words[addr[9:2]];
        endfunction

        // byte address of one word of a block
        function automatic word_t blk_addr(input int tag, input int set, input int word);
                return 32'(tag * 64 + set * 8 + word * 4);
        endfunction

        task automatic abort_run(input string why);
                $display("%s", why);
                $display("TEST FAIL");
                $fatal(1);
        endtask

        task automatic check_val(input string name, input word_t got, input word_t exp);
                if (got !== exp) begin
                        abort_run($sformatf("MISMATCH %s: got 0x%08h expected 0x%08h",
                                            name, got, exp));
                end
        endtask

        task automatic wait_for_hit(input string what);
                int n;
                n = 0;
                @(posedge CLK);
                while (!dhit && n < HIT_TIMEOUT) begin
                        @(posedge CLK);
                        n++;
                end
                if (!dhit) begin
                        abort_run($sformatf("timeout waiting for dhit on %s", what));
                end
        endtask

        task automatic access(input logic wr, input word_t addr, input word_t data);
                @(negedge CLK);
                dmemREN   = !wr;
                dmemWEN   = wr;
                dmemaddr  = addr;
                dmemstore = data;
                wait_for_hit($sformatf("%s at 0x%08h", wr ? "store" : "load", addr));
                @(negedge CLK);
                dmemREN = 1'b0;
                dmemWEN = 1'b0;
        endtask

        always @(posedge CLK) begin
                if (!nRST) begin
                        mem_reads <= 0;
                end else if (dREN && !dwait) begin
                        mem_reads <= mem_reads + 1;
                end
        end

        // loads compared and stores recorded as they complete
        always @(posedge CLK) begin
                if (nRST && dhit) begin
                        if (dmemREN) begin
                                check_val("dmemload", dmemload, ref_word(dmemaddr));
                        end
                        if (dmemWEN) begin
                                ref_mem[dmemaddr[9:2]] = dmemstore;
                        end
                end
        end

        initial begin
                int    n;
                int    reads_before;
                word_t a;
                void'($urandom(22374));
                dmemREN   = 1'b0;
                dmemWEN   = 1'b0;
                halt      = 1'b0;
                dmemaddr  = '0;
                dmemstore = '0;

                n = 0;
                while (!nRST && n < RESET_TIMEOUT) begin
                        @(posedge CLK);
                        n++;
                end
                if (!nRST) begin
                        abort_run("reset was never released");
                end
                for (int i = 0; i < 256; i++) begin
                        ref_mem[i] = memory.words[i];
                end

                // read miss then hits on the same block
                access(1'b0, blk_addr(1, 2, 0), '0);
                reads_before = mem_reads;
                access(1'b0, blk_addr(1, 2, 0), '0);
                access(1'b0, blk_addr(1, 2, 1), '0);
                check_val("memory reads on hit", 32'(mem_reads - reads_before), '0);

                // store miss and store hit each read back
                access(1'b1, blk_addr(3, 1, 1), 32'hDEAD_0001);
                access(1'b0, blk_addr(3, 1, 1), '0);
                access(1'b1, blk_addr(3, 1, 1), 32'hDEAD_0002);
                access(1'b0, blk_addr(3, 1, 1), '0);
                access(1'b0, blk_addr(3, 1, 0), '0);

                // three tags in set 5 evict dirty tag 2
                access(1'b1, blk_addr(2, 5, 0), 32'hA000_0000);
                access(1'b1, blk_addr(2, 5, 1), 32'hA000_0001);
                access(1'b1, blk_addr(3, 5, 0), 32'hB000_0000);
                access(1'b1, blk_addr(4, 5, 1), 32'hC000_0001);
                check_val("mem word tag2 set5 w0", mem_word(blk_addr(2, 5, 0)), 32'hA000_0000);
                check_val("mem word tag2 set5 w1", mem_word(blk_addr(2, 5, 1)), 32'hA000_0001);
                access(1'b0, blk_addr(2, 5, 0), '0);
                access(1'b0, blk_addr(2, 5, 1), '0);

                // LRU in set 6 with A B A C leaves A resident and B evicted
                access(1'b0, blk_addr(1, 6, 0), '0);
                access(1'b0, blk_addr(2, 6, 0), '0);
                access(1'b0, blk_addr(1, 6, 1), '0);
                access(1'b0, blk_addr(3, 6, 0), '0);
                reads_before = mem_reads;
                access(1'b0, blk_addr(1, 6, 0), '0);
                check_val("memory reads on tag A", 32'(mem_reads - reads_before), '0);
                reads_before = mem_reads;
                access(1'b0, blk_addr(2, 6, 0), '0);
                if (mem_reads == reads_before) begin
                        abort_run("read of evicted tag B in set 6 caused no memory read");
                end

                // random traffic over the first 128 words
                for (int i = 0; i < 200; i++) begin
                        a = 32'($urandom_range(127, 0)) << 2;
                        if ($urandom_range(1, 0) == 1) begin
                                access(1'b1, a, $urandom);
                        end else begin
                                access(1'b0, a, '0);
                        end
                end

                @(negedge CLK);
                check_val("flushed before halt", 32'(flushed), '0);
                halt = 1'b1;
                n = 0;
                @(posedge CLK);
                while (!flushed && n < FLUSH_TIMEOUT) begin
                        @(posedge CLK);
                        n++;
                end
                if (!flushed) begin
                        abort_run("timeout waiting for flushed after halt");
                end
                for (int i = 0; i < 256; i++) begin
                        check_val($sformatf("memory word %0d", i), memory.words[i], ref_mem[i]);
                end

                $display("TEST PASS");
                $finish;
        end

endmodule

// ==== verilog.f ====
+incdir+design
design/cache_types_pkg.sv
design/cache_ctrl_pkg.sv
design/dcache_ways.sv
design/dcache_ctrl.sv
design/dcache.sv
verif/clk_gen.sv
verif/mem_model.sv
verif/dcache_tb.sv

// ==== Makefile ====
VERILATOR ?= verilator
TOP       := dcache_tb
FILELIST  := verilog.f
OBJ_DIR   := obj_dir
FLAGS     := --binary --timing -j 0
LINTFLAGS := --lint-only --timing

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

run: build
	./$(OBJ_DIR)/V$(TOP)

lint:
	$(VERILATOR) $(LINTFLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR)
